/* compile.f */
hw/rvm_pkg.sv
hw/rvm_regfile.sv
hw/rvm_core.sv
hw/mm_periph.sv
hw/mm_ram.sv
hw/rvm_wrapper.sv
dv/tb_rvm_wrapper.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and decides pass or fail
# from the simulation log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_rvm_wrapper -o tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^No errors$" "$log"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* dv/tb_rvm_wrapper.sv */
////////////////////////////////////////////////////////////////////////////
// Testbench for the RV32I-subset test subsystem. It assembles random
// programs, loads them into the RAM model by backdoor, runs them on the
// DUT and on a reference model, and compares the exit and status outputs
////////////////////////////////////////////////////////////////////////////

module tb_rvm_wrapper;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int PROGRAMS       = 8;
    localparam int TIMEOUT_CYCLES = 5 * PROGRAMS * 400;
    localparam int MEM_WORDS      = 2**(rvm_pkg::RAM_ADDR_WIDTH - 2);

    logic                     clk;
    logic                     rst_n;
    logic                     fetch_enable;
    logic                     tests_passed;
    logic                     tests_failed;
    logic                     exit_valid;
    logic [rvm_pkg::XLEN-1:0] exit_value;

    integer      seed = 32'h4b75;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    logic [31:0] prog [$];
    logic [31:0] model_mem [MEM_WORDS];

    rvm_wrapper uut (
        .clk_i          ( clk          ),
        .rst_n_i        ( rst_n        ),
        .fetch_enable_i ( fetch_enable ),
        .tests_passed_o ( tests_passed ),
        .tests_failed_o ( tests_failed ),
        .exit_valid_o   ( exit_valid   ),
        .exit_value_o   ( exit_value   )
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    function automatic int urand(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // x31 is kept as the peripheral base, so random picks avoid it
    function automatic logic [4:0] rand_reg();
        return 5'(1 + urand(30));
    endfunction

    // unused words decode as opcode 0, which the core treats as a no-op
    function automatic logic [31:0] fill_word(int idx);
        return {idx[9:0], 22'h0};
    endfunction

    function automatic logic [31:0] lui_word(logic [4:0] rd, logic [19:0] imm);
        rvm_pkg::instr_u w;
        w = '0;
        w.u_fmt.imm    = imm;
        w.u_fmt.rd     = rd;
        w.u_fmt.opcode = rvm_pkg::OPC_LUI;
        return w;
    endfunction

    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1,
                                              logic [11:0] imm);
        rvm_pkg::instr_u w;
        w = '0;
        w.i_fmt.imm    = imm;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = rvm_pkg::F3_ADD;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = rvm_pkg::OPC_OPIMM;
        return w;
    endfunction

    function automatic logic [31:0] alu_word(logic [2:0] f3, logic [4:0] rd,
                                             logic [4:0] rs1, logic [4:0] rs2);
        rvm_pkg::instr_u w;
        w = '0;
        w.r_fmt.rs2    = rs2;
        w.r_fmt.rs1    = rs1;
        w.r_fmt.funct3 = f3;
        w.r_fmt.rd     = rd;
        w.r_fmt.opcode = rvm_pkg::OPC_OP;
        return w;
    endfunction

    function automatic logic [31:0] load_word(logic [4:0] rd, logic [4:0] rs1,
                                              logic [11:0] off);
        rvm_pkg::instr_u w;
        w = '0;
        w.i_fmt.imm    = off;
        w.i_fmt.rs1    = rs1;
        w.i_fmt.funct3 = 3'b010;
        w.i_fmt.rd     = rd;
        w.i_fmt.opcode = rvm_pkg::OPC_LOAD;
        return w;
    endfunction

    function automatic logic [31:0] store_word(logic [4:0] rs2, logic [4:0] rs1,
                                               logic [11:0] off);
        rvm_pkg::instr_u w;
        w = '0;
        w.s_fmt.imm_hi = off[11:5];
        w.s_fmt.rs2    = rs2;
        w.s_fmt.rs1    = rs1;
        w.s_fmt.funct3 = 3'b010;
        w.s_fmt.imm_lo = off[4:0];
        w.s_fmt.opcode = rvm_pkg::OPC_STORE;
        return w;
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1,
                                                logic [4:0] rs2, logic [12:0] off);
        rvm_pkg::instr_u w;
        w = '0;
        w.b_fmt.imm12   = off[12];
        w.b_fmt.imm10_5 = off[10:5];
        w.b_fmt.rs2     = rs2;
        w.b_fmt.rs1     = rs1;
        w.b_fmt.funct3  = f3;
        w.b_fmt.imm4_1  = off[4:1];
        w.b_fmt.imm11   = off[11];
        w.b_fmt.opcode  = rvm_pkg::OPC_BRANCH;
        return w;
    endfunction

    // LUI plus ADDI, with the upper part rounded for the signed low half
    task automatic load_const(logic [4:0] rd, logic [31:0] val);
        prog.push_back(lui_word(rd, val[31:12] + {19'd0, val[11]}));
        prog.push_back(addi_word(rd, rd, val[11:0]));
    endtask

    task automatic set_periph_base();
        prog.push_back(lui_word(5'd31, rvm_pkg::PERIPH_BASE[31:12]));
    endtask

    // writes src to the exit register, then spins on a BEQ to itself
    task automatic append_exit(logic [4:0] src);
        set_periph_base();
        prog.push_back(store_word(src, 5'd31, 12'({rvm_pkg::EXIT_OFFSET, 2'b00})));
        prog.push_back(branch_word(rvm_pkg::F3_BEQ, 5'd0, 5'd0, 13'd0));
    endtask

    task automatic check_value(string name, logic [31:0] exp, logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // executes model_mem from the boot address until the exit write
    task automatic model_run(string name, output logic [31:0] exit_val,
                             output logic status_seen, output logic [31:0] status_val);
        logic [31:0]     r [32];
        logic [31:0]     pc;
        logic [31:0]     next_pc;
        logic [31:0]     addr;
        logic [31:0]     a;
        logic [31:0]     b;
        rvm_pkg::instr_u w;
        logic            done;
        int              steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        pc          = rvm_pkg::BOOT_ADDR;
        done        = 1'b0;
        steps       = 0;
        exit_val    = '0;
        status_seen = 1'b0;
        status_val  = '0;
        while (!done && steps < 4000) begin
            w       = model_mem[pc[11:2]];
            a       = r[w.r_fmt.rs1];
            b       = r[w.r_fmt.rs2];
            next_pc = pc + 32'd4;
            case (w.r_fmt.opcode)
                rvm_pkg::OPC_LUI: r[w.u_fmt.rd] = {w.u_fmt.imm, 12'h000};
                rvm_pkg::OPC_OPIMM: begin
                    if (w.i_fmt.funct3 == rvm_pkg::F3_ADD) begin
                        r[w.i_fmt.rd] = a + {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
                    end
                end
                rvm_pkg::OPC_OP: begin
                    if (w.r_fmt.funct3 == rvm_pkg::F3_ADD) begin
                        r[w.r_fmt.rd] = a + b;
                    end else if (w.r_fmt.funct3 == rvm_pkg::F3_XOR) begin
                        r[w.r_fmt.rd] = a ^ b;
                    end
                end
                rvm_pkg::OPC_LOAD: begin
                    addr = a + {{20{w.i_fmt.imm[11]}}, w.i_fmt.imm};
                    // the peripheral region reads as zero
                    r[w.i_fmt.rd] = (addr[31:28] == 4'h2) ? 32'd0 : model_mem[addr[11:2]];
                end
                rvm_pkg::OPC_STORE: begin
                    addr = a + {{20{w.s_fmt.imm_hi[6]}}, w.s_fmt.imm_hi, w.s_fmt.imm_lo};
                    if (addr[31:28] != 4'h2) begin
                        model_mem[addr[11:2]] = b;
                    end else if (addr[3:2] == 2'd0) begin
                        status_seen = 1'b1;
                        status_val  = b;
                    end else if (addr[3:2] == 2'd1) begin
                        exit_val = b;
                        done     = 1'b1;
                    end
                end
                rvm_pkg::OPC_BRANCH: begin
                    if ((w.b_fmt.funct3 == rvm_pkg::F3_BEQ && a == b) ||
                        (w.b_fmt.funct3 == rvm_pkg::F3_BNE && a != b)) begin
                        next_pc = pc + {{19{w.b_fmt.imm12}}, w.b_fmt.imm12, w.b_fmt.imm11,
                                        w.b_fmt.imm10_5, w.b_fmt.imm4_1, 1'b0};
                    end
                end
                default: ;
            endcase
            r[0] = '0;
            pc   = next_pc;
            steps++;
        end
        if (!done) begin
            errors++;
            $display("reference model never reached the exit write in %s", name);
        end
    endtask

    // two reset cycles, with the program loaded while reset is held
    task automatic run_program(string name);
        logic [31:0] exp_exit;
        logic [31:0] exp_status;
        logic        status_seen;
        logic [31:0] w;
        int          wait_cycles;
        rst_n        = 1'b0;
        fetch_enable = 1'b0;
        @(posedge clk);
        #1;
        for (int idx = 0; idx < MEM_WORDS; idx++) begin
            w                   = (idx < prog.size()) ? prog[idx] : fill_word(idx);
            model_mem[idx]      = w;
            uut.ram_i.mem[idx]  = w;
        end
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        model_run(name, exp_exit, status_seen, exp_status);
        // outputs stay quiet while the core waits for fetch_enable_i
        wait_cycles = 5 + urand(16);
        for (int c = 0; c < wait_cycles; c++) begin
            @(posedge clk);
            #1;
            check_value({name, " idle tests_passed_o"}, 32'd0, {31'd0, tests_passed});
            check_value({name, " idle tests_failed_o"}, 32'd0, {31'd0, tests_failed});
            check_value({name, " idle exit_valid_o"}, 32'd0, {31'd0, exit_valid});
            check_value({name, " idle exit_value_o"}, 32'd0, exit_value);
        end
        fetch_enable = 1'b1;
        while (!exit_valid) begin
            @(posedge clk);
            #1;
        end
        check_value({name, " exit_value_o"}, exp_exit, exit_value);
        check_value({name, " tests_passed_o"}, {31'd0, status_seen && exp_status == 32'd1},
                    {31'd0, tests_passed});
        check_value({name, " tests_failed_o"}, {31'd0, status_seen && exp_status != 32'd1},
                    {31'd0, tests_failed});
    endtask

    initial begin
        int          n;
        int          count;
        logic [4:0]  rd;
        logic [4:0]  ra;
        logic [4:0]  rb;
        logic [11:0] imm;
        logic [11:0] off [4];
        logic [31:0] val;
        clk          = 1'b0;
        rst_n        = 1'b0;
        fetch_enable = 1'b0;

        for (int p = 0; p < PROGRAMS; p++) begin
            prog.delete();
            n = 4 + urand(9);
            for (int k = 0; k < n; k++) begin
                rd = rand_reg();
                case ((k < 2) ? 0 : urand(4))
                    0: prog.push_back(lui_word(rd, 20'($random(seed))));
                    1: prog.push_back(addi_word(rd, rand_reg(), 12'($random(seed))));
                    2: prog.push_back(alu_word(rvm_pkg::F3_ADD, rd, rand_reg(), rand_reg()));
                    default: prog.push_back(alu_word(rvm_pkg::F3_XOR, rd, rand_reg(),
                                                     rand_reg()));
                endcase
            end
            // the last destination register carries the chain's result
            append_exit(rd);
            run_program("arith");
        end

        // data words sit well above the program, one per 64-word slot
        for (int p = 0; p < PROGRAMS; p++) begin
            prog.delete();
            n = 2 + urand(3);
            for (int k = 0; k < n; k++) begin
                off[k] = 12'((128 + k * 64 + urand(64)) * 4);
                load_const(5'(1 + k), $random(seed));
                prog.push_back(store_word(5'(1 + k), 5'd0, off[k]));
            end
            for (int k = n - 1; k >= 0; k--) begin
                prog.push_back(load_word(5'(11 + k), 5'd0, off[k]));
                prog.push_back(alu_word(rvm_pkg::F3_XOR, 5'd21, 5'd21, 5'(11 + k)));
            end
            append_exit(5'd21);
            run_program("memory");
        end

        for (int p = 0; p < PROGRAMS; p++) begin
            prog.delete();
            count = 1 + urand(15);
            imm   = 12'($random(seed));
            ra    = rand_reg();
            rb    = (ra == 5'd30) ? 5'd1 : ra + 5'd1;
            prog.push_back(addi_word(ra, 5'd0, 12'(count)));
            prog.push_back(addi_word(rb, 5'd0, 12'd0));
            prog.push_back(addi_word(rb, rb, imm));
            prog.push_back(addi_word(ra, ra, 12'hfff));
            prog.push_back(branch_word(rvm_pkg::F3_BNE, ra, 5'd0, 13'(-8)));
            // the taken BEQ jumps over the poisoning ADDI
            prog.push_back(branch_word(rvm_pkg::F3_BEQ, 5'd0, 5'd0, 13'd8));
            prog.push_back(addi_word(rb, rb, 12'h7ff));
            append_exit(rb);
            run_program("branch");
            check_value("branch count*imm", {{20{imm[11]}}, imm} * 32'(count), exit_value);
        end

        for (int p = 0; p < PROGRAMS; p++) begin
            prog.delete();
            val = (urand(2) == 0) ? 32'd1 : $random(seed);
            set_periph_base();
            load_const(5'd5, val);
            prog.push_back(store_word(5'd5, 5'd31, 12'({rvm_pkg::STATUS_OFFSET, 2'b00})));
            load_const(5'd6, $random(seed));
            append_exit(5'd6);
            run_program("status");
        end

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* hw/rvm_wrapper.sv */
////////////////////////////////////////////////////////////////////////////
// Top level of the test subsystem: the core, its RAM model and the
// pseudo peripherals. Raise fetch_enable_i after reset and wait for
// exit_valid_o to see the program's result
////////////////////////////////////////////////////////////////////////////

module rvm_wrapper (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_enable_i,
    output logic                     tests_passed_o,
    output logic                     tests_failed_o,
    output logic                     exit_valid_o,
    output logic [rvm_pkg::XLEN-1:0] exit_value_o
);

    logic                                 instr_req;
    logic                                 instr_gnt;
    logic                                 instr_rvalid;
    logic [rvm_pkg::XLEN-1:0]             instr_addr;
    logic [rvm_pkg::XLEN-1:0]             instr_rdata;

    logic                                 data_req;
    logic                                 data_gnt;
    logic                                 data_rvalid;
    logic [rvm_pkg::XLEN-1:0]             data_addr;
    logic                                 data_we;
    logic [rvm_pkg::XLEN-1:0]             data_wdata;
    logic [rvm_pkg::XLEN-1:0]             data_rdata;

    logic                                 per_we;
    logic [rvm_pkg::PER_OFFSET_WIDTH-1:0] per_offset;
    logic [rvm_pkg::XLEN-1:0]             per_wdata;

    rvm_core core_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .fetch_enable_i ( fetch_enable_i ),
        .instr_req_o    ( instr_req      ),
        .instr_addr_o   ( instr_addr     ),
        .instr_gnt_i    ( instr_gnt      ),
        .instr_rvalid_i ( instr_rvalid   ),
        .instr_rdata_i  ( instr_rdata    ),
        .data_req_o     ( data_req       ),
        .data_addr_o    ( data_addr      ),
        .data_we_o      ( data_we        ),
        .data_wdata_o   ( data_wdata     ),
        .data_gnt_i     ( data_gnt       ),
        .data_rvalid_i  ( data_rvalid    ),
        .data_rdata_i   ( data_rdata     )
    );

    // the instruction port only sees the RAM's own address bits
    mm_ram ram_i (
        .clk_i          ( clk_i                                    ),
        .rst_n_i        ( rst_n_i                                  ),
        .instr_req_i    ( instr_req                                ),
        .instr_addr_i   ( instr_addr[rvm_pkg::RAM_ADDR_WIDTH-1:0]  ),
        .instr_gnt_o    ( instr_gnt                                ),
        .instr_rvalid_o ( instr_rvalid                             ),
        .instr_rdata_o  ( instr_rdata                              ),
        .data_req_i     ( data_req                                 ),
        .data_addr_i    ( data_addr                                ),
        .data_we_i      ( data_we                                  ),
        .data_wdata_i   ( data_wdata                               ),
        .data_gnt_o     ( data_gnt                                 ),
        .data_rvalid_o  ( data_rvalid                              ),
        .data_rdata_o   ( data_rdata                               ),
        .per_we_o       ( per_we                                   ),
        .per_offset_o   ( per_offset                               ),
        .per_wdata_o    ( per_wdata                                )
    );

    mm_periph periph_i (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .we_i           ( per_we         ),
        .offset_i       ( per_offset     ),
        .wdata_i        ( per_wdata      ),
        .tests_passed_o ( tests_passed_o ),
        .tests_failed_o ( tests_failed_o ),
        .exit_valid_o   ( exit_valid_o   ),
        .exit_value_o   ( exit_value_o   )
    );

endmodule

/* hw/mm_ram.sv */
////////////////////////////////////////////////////////////////////////////
// Word RAM model with an instruction port and a data port. Both grant in
// the request cycle and answer one cycle later. Data writes to the
// peripheral region are passed on to mm_periph instead of the array.
// The testbench loads programs straight into mem
////////////////////////////////////////////////////////////////////////////

module mm_ram (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,

    input  logic                                 instr_req_i,
    input  logic [rvm_pkg::RAM_ADDR_WIDTH-1:0]   instr_addr_i,
    output logic                                 instr_gnt_o,
    output logic                                 instr_rvalid_o,
    output logic [rvm_pkg::XLEN-1:0]             instr_rdata_o,

    input  logic                                 data_req_i,
    input  logic [rvm_pkg::XLEN-1:0]             data_addr_i,
    input  logic                                 data_we_i,
    input  logic [rvm_pkg::XLEN-1:0]             data_wdata_i,
    output logic                                 data_gnt_o,
    output logic                                 data_rvalid_o,
    output logic [rvm_pkg::XLEN-1:0]             data_rdata_o,

    output logic                                 per_we_o,
    output logic [rvm_pkg::PER_OFFSET_WIDTH-1:0] per_offset_o,
    output logic [rvm_pkg::XLEN-1:0]             per_wdata_o
);

    logic [rvm_pkg::XLEN-1:0]             mem [2**(rvm_pkg::RAM_ADDR_WIDTH-2)];
    logic [rvm_pkg::RAM_ADDR_WIDTH-3:0]   instr_idx;
    logic [rvm_pkg::RAM_ADDR_WIDTH-3:0]   data_idx;
    logic                                 data_periph;

    assign instr_idx   = instr_addr_i[rvm_pkg::RAM_ADDR_WIDTH-1:2];
    assign data_idx    = data_addr_i[rvm_pkg::RAM_ADDR_WIDTH-1:2];
    assign data_periph = data_addr_i[31:28] == rvm_pkg::PERIPH_BASE[31:28];

    // no back-pressure
    assign instr_gnt_o = instr_req_i;
    assign data_gnt_o  = data_req_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            instr_rvalid_o <= 1'b0;
            data_rvalid_o  <= 1'b0;
        end else begin
            instr_rvalid_o <= instr_req_i;
            data_rvalid_o  <= data_req_i;
        end
    end

    always @(posedge clk_i) begin
        instr_rdata_o <= mem[instr_idx];
        // writes and peripheral reads answer with zero
        data_rdata_o  <= (data_we_i || data_periph) ? '0 : mem[data_idx];
        if (data_req_i && data_we_i && !data_periph) begin
            mem[data_idx] <= data_wdata_i;
        end
    end

    assign per_we_o     = data_req_i && data_gnt_o && data_we_i && data_periph;
    assign per_offset_o = data_addr_i[rvm_pkg::PER_OFFSET_WIDTH+1:2];
    assign per_wdata_o  = data_wdata_i;

endmodule

/* hw/mm_periph.sv */
////////////////////////////////////////////////////////////////////////////
// Pseudo peripherals of the test subsystem. A status write of 1 means
// pass, any other value means fail; an exit write ends the program.
// All flags hold until reset
////////////////////////////////////////////////////////////////////////////

module mm_periph (
    input  logic                                 clk_i,
    input  logic                                 rst_n_i,
    input  logic                                 we_i,
    input  logic [rvm_pkg::PER_OFFSET_WIDTH-1:0] offset_i,
    input  logic [rvm_pkg::XLEN-1:0]             wdata_i,
    output logic                                 tests_passed_o,
    output logic                                 tests_failed_o,
    output logic                                 exit_valid_o,
    output logic [rvm_pkg::XLEN-1:0]             exit_value_o
);

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            tests_passed_o <= 1'b0;
            tests_failed_o <= 1'b0;
            exit_valid_o   <= 1'b0;
            exit_value_o   <= '0;
        end else if (we_i) begin
            if (offset_i == rvm_pkg::STATUS_OFFSET) begin
                if (wdata_i == 32'd1) begin
                    tests_passed_o <= 1'b1;
                end else begin
                    tests_failed_o <= 1'b1;
                end
            end
            if (offset_i == rvm_pkg::EXIT_OFFSET) begin
                exit_valid_o <= 1'b1;
                exit_value_o <= wdata_i;
            end
        end
    end

endmodule

/* hw/rvm_core.sv */
////////////////////////////////////////////////////////////////////////////
// Minimal non-pipelined RV32I-subset core (LUI, ADDI, ADD, XOR, LW, SW,
// BEQ, BNE). Other opcodes retire as no-ops. It masters the instruction
// and data buses and starts fetching once fetch_enable_i is sampled high
////////////////////////////////////////////////////////////////////////////

module rvm_core (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic                     fetch_enable_i,

    output logic                     instr_req_o,
    output logic [rvm_pkg::XLEN-1:0] instr_addr_o,
    input  logic                     instr_gnt_i,
    input  logic                     instr_rvalid_i,
    input  logic [rvm_pkg::XLEN-1:0] instr_rdata_i,

    output logic                     data_req_o,
    output logic [rvm_pkg::XLEN-1:0] data_addr_o,
    output logic                     data_we_o,
    output logic [rvm_pkg::XLEN-1:0] data_wdata_o,
    input  logic                     data_gnt_i,
    input  logic                     data_rvalid_i,
    input  logic [rvm_pkg::XLEN-1:0] data_rdata_i
);

    logic [1:0]               state_q;
    logic [1:0]               state_d;
    logic [rvm_pkg::XLEN-1:0] pc_q;
    logic [rvm_pkg::XLEN-1:0] pc_d;
    logic                     req_pending_q;
    logic                     req_pending_d;
    logic [rvm_pkg::XLEN-1:0] instr_q;
    rvm_pkg::instr_u          instr;

    logic                     exec;
    logic                     is_load;
    logic                     is_store;
    logic [rvm_pkg::XLEN-1:0] rs1_val;
    logic [rvm_pkg::XLEN-1:0] rs2_val;
    logic [rvm_pkg::XLEN-1:0] imm_i;
    logic [rvm_pkg::XLEN-1:0] imm_s;
    logic [rvm_pkg::XLEN-1:0] imm_b;
    logic [rvm_pkg::XLEN-1:0] imm_u;
    logic                     alu_we;
    logic [rvm_pkg::XLEN-1:0] alu_result;
    logic                     branch_taken;
    logic                     rf_we;
    logic [rvm_pkg::XLEN-1:0] rf_wdata;

    // the word is decoded straight off the bus in its execute cycle
    assign instr = (state_q == rvm_pkg::ST_WAIT_INSTR) ? instr_rdata_i : instr_q;
    assign exec  = (state_q == rvm_pkg::ST_WAIT_INSTR) && instr_rvalid_i;

    assign is_load  = instr.r_fmt.opcode == rvm_pkg::OPC_LOAD;
    assign is_store = instr.r_fmt.opcode == rvm_pkg::OPC_STORE;

    assign imm_i = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
    assign imm_s = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
    assign imm_b = {{19{instr.b_fmt.imm12}}, instr.b_fmt.imm12, instr.b_fmt.imm11,
                    instr.b_fmt.imm10_5, instr.b_fmt.imm4_1, 1'b0};
    assign imm_u = {instr.u_fmt.imm, 12'b0};

    rvm_regfile regfile_i (
        .clk_i     ( clk_i              ),
        .rst_n_i   ( rst_n_i            ),
        .raddr_a_i ( instr.r_fmt.rs1    ),
        .raddr_b_i ( instr.r_fmt.rs2    ),
        .rdata_a_o ( rs1_val            ),
        .rdata_b_o ( rs2_val            ),
        .we_i      ( rf_we              ),
        .waddr_i   ( instr.r_fmt.rd     ),
        .wdata_i   ( rf_wdata           )
    );

    always_comb begin
        alu_we       = 1'b0;
        alu_result   = '0;
        branch_taken = 1'b0;
        case (instr.r_fmt.opcode)
            rvm_pkg::OPC_LUI: begin
                alu_we     = 1'b1;
                alu_result = imm_u;
            end
            rvm_pkg::OPC_OPIMM: begin
                // only ADDI is implemented
                alu_we     = instr.i_fmt.funct3 == rvm_pkg::F3_ADD;
                alu_result = rs1_val + imm_i;
            end
            rvm_pkg::OPC_OP: begin
                alu_we     = (instr.r_fmt.funct3 == rvm_pkg::F3_ADD) ||
                             (instr.r_fmt.funct3 == rvm_pkg::F3_XOR);
                alu_result = (instr.r_fmt.funct3 == rvm_pkg::F3_XOR) ?
                             (rs1_val ^ rs2_val) : (rs1_val + rs2_val);
            end
            rvm_pkg::OPC_BRANCH: begin
                if (instr.b_fmt.funct3 == rvm_pkg::F3_BEQ) begin
                    branch_taken = rs1_val == rs2_val;
                end else if (instr.b_fmt.funct3 == rvm_pkg::F3_BNE) begin
                    branch_taken = rs1_val != rs2_val;
                end
            end
            default: begin
                alu_we = 1'b0;
            end
        endcase
    end

    // ALU results land in the execute cycle, load data when it returns
    assign rf_we    = (exec && alu_we) ||
                      (state_q == rvm_pkg::ST_WAIT_DATA && data_rvalid_i && is_load);
    assign rf_wdata = exec ? alu_result : data_rdata_i;

    assign instr_req_o  = state_q == rvm_pkg::ST_FETCH;
    assign instr_addr_o = pc_q;

    assign data_req_o   = (exec && (is_load || is_store)) ||
                          (state_q == rvm_pkg::ST_WAIT_DATA && req_pending_q);
    assign data_addr_o  = rs1_val + (is_store ? imm_s : imm_i);
    assign data_we_o    = is_store;
    assign data_wdata_o = rs2_val;

    always_comb begin
        state_d       = state_q;
        pc_d          = pc_q;
        req_pending_d = req_pending_q;
        case (state_q)
            rvm_pkg::ST_IDLE: begin
                if (fetch_enable_i) begin
                    state_d = rvm_pkg::ST_FETCH;
                end
            end
            rvm_pkg::ST_FETCH: begin
                if (instr_gnt_i) begin
                    state_d = rvm_pkg::ST_WAIT_INSTR;
                end
            end
            rvm_pkg::ST_WAIT_INSTR: begin
                if (instr_rvalid_i && (is_load || is_store)) begin
                    // keep requesting from instr_q until the grant comes
                    state_d       = rvm_pkg::ST_WAIT_DATA;
                    req_pending_d = !data_gnt_i;
                end else if (instr_rvalid_i) begin
                    state_d = rvm_pkg::ST_FETCH;
                    pc_d    = branch_taken ? pc_q + imm_b : pc_q + 32'd4;
                end
            end
            rvm_pkg::ST_WAIT_DATA: begin
                if (data_gnt_i) begin
                    req_pending_d = 1'b0;
                end
                if (data_rvalid_i) begin
                    state_d = rvm_pkg::ST_FETCH;
                    pc_d    = pc_q + 32'd4;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q       <= rvm_pkg::ST_IDLE;
            pc_q          <= rvm_pkg::BOOT_ADDR;
            req_pending_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            pc_q          <= pc_d;
            req_pending_q <= req_pending_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exec) begin
            instr_q <= instr_rdata_i;
        end
    end

endmodule

/* hw/rvm_regfile.sv */
////////////////////////////////////////////////////////////////////////////
// Register file of the core: 32 registers, two combinational read ports
// and one write port. x0 always reads as zero
////////////////////////////////////////////////////////////////////////////

module rvm_regfile (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  logic [4:0]               raddr_a_i,
    input  logic [4:0]               raddr_b_i,
    output logic [rvm_pkg::XLEN-1:0] rdata_a_o,
    output logic [rvm_pkg::XLEN-1:0] rdata_b_o,
    input  logic                     we_i,
    input  logic [4:0]               waddr_i,
    input  logic [rvm_pkg::XLEN-1:0] wdata_i
);

    // x0 has no storage
    logic [rvm_pkg::XLEN-1:0] regs [1:31];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata_a_o = (raddr_a_i == 5'd0) ? '0 : regs[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == 5'd0) ? '0 : regs[raddr_b_i];

endmodule

/* hw/rvm_pkg.sv */
////////////////////////////////////////////////////////////////////////////
// Shared definitions for the RV32I-subset test subsystem: widths, memory
// map, FSM and opcode encodings and the instruction word union. Other
// files refer to these through rvm_pkg:: scoped names
////////////////////////////////////////////////////////////////////////////

package rvm_pkg;

    localparam int XLEN           = 32;
    localparam int RAM_ADDR_WIDTH = 12;

    localparam logic [XLEN-1:0] BOOT_ADDR   = 32'h0000_0000;
    // data addresses with this top nibble go to the peripherals
    localparam logic [XLEN-1:0] PERIPH_BASE = 32'h2000_0000;

    // word offsets inside the peripheral region
    localparam int PER_OFFSET_WIDTH = 2;
    localparam logic [PER_OFFSET_WIDTH-1:0] STATUS_OFFSET = 2'd0;
    localparam logic [PER_OFFSET_WIDTH-1:0] EXIT_OFFSET   = 2'd1;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OPIMM  = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;

    // core FSM states
    localparam logic [1:0] ST_IDLE       = 2'd0;
    localparam logic [1:0] ST_FETCH      = 2'd1;
    localparam logic [1:0] ST_WAIT_INSTR = 2'd2;
    localparam logic [1:0] ST_WAIT_DATA  = 2'd3;

    // one instruction word seen through each encoding format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_u;

endpackage
